//--- rv_core.f
src/rv_pkg.sv
src/rv_fetch.sv
src/rv_decode.sv
src/rv_regfile.sv
src/rv_execute.sv
src/rv_store_port.sv
src/rv_core.sv
test/rv_core_props.sv
test/rv_core_tb.sv

//--- test/rv_core_tb.sv
`timescale 1ns/1ns
`default_nettype none

module rv_core_tb;

    localparam int TIMEOUT = 20000;

    logic            clk;
    logic            rst_n;
    rv_pkg::wb_req_t ibus_req;
    rv_pkg::wb_rsp_t ibus_rsp;
    rv_pkg::wb_req_t dbus_req;
    rv_pkg::wb_rsp_t dbus_rsp;

    logic [31:0] prog [0:255];
    int          n;              // Next program slot
    integer      seed = 92574;
    int          i_wait;
    int          d_wait;
    logic [31:0] exp_adr [$];
    logic [31:0] exp_dat [$];
    logic [31:0] got_adr [$];
    logic [31:0] got_dat [$];
    int          idx;            // Stores compared in this test
    int          errors;
    int          tests_run;
    int          tests_failed;
    string       test_name;

    rv_core i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .ibus_req_o (ibus_req),
        .ibus_rsp_i (ibus_rsp),
        .dbus_req_o (dbus_req),
        .dbus_rsp_i (dbus_rsp)
    );

    always #5 clk = ~clk;

    // --------------------------------------------------
    // Bus slaves with random wait states
    // --------------------------------------------------
    always @(posedge clk) begin
        #1;
        if (!rst_n || ibus_rsp.ack) begin
            ibus_rsp.ack = 1'b0;
        end else if (ibus_req.stb) begin
            if (i_wait == 0) begin
                ibus_rsp.ack = 1'b1;
                ibus_rsp.dat = prog[ibus_req.adr[9:2]];
                i_wait = $unsigned($random(seed)) % 4;
            end else begin
                i_wait--;
            end
        end
    end

    always @(posedge clk) begin
        #1;
        if (!rst_n || dbus_rsp.ack) begin
            dbus_rsp.ack = 1'b0;
        end else if (dbus_req.stb) begin
            if (d_wait == 0) begin
                dbus_rsp.ack = 1'b1;
                got_adr.push_back(dbus_req.adr);
                got_dat.push_back(dbus_req.dat);
                d_wait = $unsigned($random(seed)) % 4;
            end else begin
                d_wait--;
            end
        end
    end

    // Compare each recorded write with the next expected one
    always @(posedge clk) begin
        logic [31:0] a;
        logic [31:0] d;
        while (got_adr.size() > 0) begin
            a = got_adr.pop_front();
            d = got_dat.pop_front();
            assert (idx < exp_adr.size()) else begin
                $display("%s: store %0d arrived but only %0d were expected",
                         test_name, idx, exp_adr.size());
                errors++;
            end
            if (idx < exp_adr.size()) begin
                assert (a == exp_adr[idx]) else begin
                    $display("CHECK FAILED %s store %0d address: expected %h actual %h",
                             test_name, idx, exp_adr[idx], a);
                    errors++;
                end
                assert (d == exp_dat[idx]) else begin
                    $display("CHECK FAILED %s store %0d data: expected %h actual %h",
                             test_name, idx, exp_dat[idx], d);
                    errors++;
                end
            end
            idx++;
        end
    end

    // --------------------------------------------------
    // Instruction encoders
    // --------------------------------------------------
    function automatic logic [31:0] rtype(bit alt, int rs2, int rs1, logic [2:0] f3, int rd);
        return {1'b0, alt, 5'b0, 5'(rs2), 5'(rs1), f3, 5'(rd), rv_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] itype(int imm, int rs1, logic [2:0] f3, int rd,
                                          logic [6:0] opc);
        return {12'(imm), 5'(rs1), f3, 5'(rd), opc};
    endfunction

    function automatic logic [31:0] stype(int imm, int rs2, int rs1);
        logic [11:0] i;
        i = 12'(imm);
        return {i[11:5], 5'(rs2), 5'(rs1), 3'b010, i[4:0], rv_pkg::OPC_STORE};
    endfunction

    function automatic logic [31:0] btype(int imm, int rs2, int rs1, logic [2:0] f3);
        logic [12:0] i;
        i = 13'(imm);
        return {i[12], i[10:5], 5'(rs2), 5'(rs1), f3, i[4:1], i[11], rv_pkg::OPC_BRANCH};
    endfunction

    function automatic logic [31:0] jtype(int imm, int rd);
        logic [20:0] i;
        i = 21'(imm);
        return {i[20], i[10:1], i[11], i[19:12], 5'(rd), rv_pkg::OPC_JAL};
    endfunction

    task automatic put(logic [31:0] w);
        prog[n] = w;
        n++;
    endtask

    // Store rs at the pointer in x31, then advance it
    task automatic put_sw(int rs);
        put(stype(0, rs, 31));
        put(itype(4, 31, rv_pkg::F3_ADD, 31, rv_pkg::OPC_OP_IMM));
    endtask

    task automatic begin_prog();
        for (int i = 0; i < 256; i++) begin
            prog[i] = {i[24:0], 7'b0000000};  // Unknown opcode, address tagged
        end
        n = 0;
        put(itype(12'h400, 0, rv_pkg::F3_ADD, 31, rv_pkg::OPC_OP_IMM));
    endtask

    // --------------------------------------------------
    // Reference ISA model, builds the expected stores
    // --------------------------------------------------
    function automatic void ref_model();
        logic [31:0] x [0:31];
        logic [31:0] pc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [31:0] im;
        logic [31:0] npc;
        logic [2:0]  f3;
        logic        t;
        int          rd;
        exp_adr.delete();
        exp_dat.delete();
        for (int i = 0; i < 32; i++) x[i] = '0;
        pc = rv_pkg::RESET_PC;
        for (int step = 0; step < 5000; step++) begin
            ins = prog[pc[9:2]];
            f3  = ins[14:12];
            rd  = ins[11:7];
            a   = x[ins[19:15]];
            b   = x[ins[24:20]];
            npc = pc + 4;
            r   = 'x;
            case (ins[6:0])
                rv_pkg::OPC_OP, rv_pkg::OPC_OP_IMM: begin
                    if (ins[6:0] == rv_pkg::OPC_OP_IMM) begin
                        b = {{20{ins[31]}}, ins[31:20]};
                    end
                    case (f3)
                        3'b000: r = (ins[6:0] == rv_pkg::OPC_OP && ins[30]) ? a - b : a + b;
                        3'b001: r = a << b[4:0];
                        3'b010: r = ($signed(a) < $signed(b)) ? 1 : 0;
                        3'b011: r = (a < b) ? 1 : 0;
                        3'b100: r = a ^ b;
                        3'b101: r = ins[30] ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
                        3'b110: r = a | b;
                        default: r = a & b;
                    endcase
                end
                rv_pkg::OPC_LUI:   r = {ins[31:12], 12'b0};
                rv_pkg::OPC_AUIPC: r = pc + {ins[31:12], 12'b0};
                rv_pkg::OPC_JAL: begin
                    im = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                    if (im == 0) break;  // Jump to self ends the program
                    r   = pc + 4;
                    npc = pc + im;
                end
                rv_pkg::OPC_JALR: begin
                    r   = pc + 4;
                    npc = (a + {{20{ins[31]}}, ins[31:20]}) & ~32'd1;
                end
                rv_pkg::OPC_BRANCH: begin
                    im = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                    case (f3)
                        3'b000: t = (a == b);
                        3'b001: t = (a != b);
                        3'b100: t = $signed(a) < $signed(b);
                        3'b101: t = $signed(a) >= $signed(b);
                        3'b110: t = a < b;
                        3'b111: t = a >= b;
                        default: t = 1'b0;
                    endcase
                    if (t) npc = pc + im;
                end
                rv_pkg::OPC_STORE: begin
                    exp_adr.push_back(a + {{20{ins[31]}}, ins[31:25], ins[11:7]});
                    exp_dat.push_back(b);
                end
                default: ;
            endcase
            if (!$isunknown(r) && rd != 0) x[rd] = r;
            pc = npc;
        end
    endfunction

    // Reset the DUT, run the loaded program and wait for its stores
    task automatic run_prog(string name);
        int cycles;
        int err_before;
        int props_before;
        put(jtype(0, 0));
        ref_model();
        test_name    = name;
        err_before   = errors;
        props_before = i_dut.i_props.fail_count;
        #1 rst_n = 1'b0;
        repeat (4) @(posedge clk);
        got_adr.delete();
        got_dat.delete();
        idx = 0;
        #1 rst_n = 1'b1;
        cycles = 0;
        while (idx < exp_adr.size() && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (idx < exp_adr.size()) begin
            $display("%s: stores stopped arriving after %0d of %0d",
                     name, idx, exp_adr.size());
            errors++;
        end
        repeat (40) @(posedge clk);  // Catch stray stores
        errors += i_dut.i_props.fail_count - props_before;  // Bus property failures
        tests_run++;
        if (errors != err_before) begin
            tests_failed++;
            $display("Test %s: FAIL (%0d errors)", name, errors - err_before);
        end else begin
            $display("Test %s: ok, %0d stores", name, idx);
        end
    endtask

    // --------------------------------------------------
    // Test programs
    // --------------------------------------------------
    initial begin
        logic [2:0] f3s [0:9];
        bit         alts [0:9];
        int         imms [0:8];
        int         av [0:2];
        int         bv [0:2];
        logic [2:0] f3;
        int         rd;
        bit         alt;
        clk = 1'b0;
        rst_n = 1'b0;
        ibus_rsp = '0;
        dbus_rsp = '0;
        i_wait = 0;
        d_wait = 0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        idx = 0;
        f3s  = '{0, 0, 1, 2, 3, 4, 5, 5, 6, 7};
        alts = '{0, 1, 0, 0, 0, 0, 0, 1, 0, 0};
        imms = '{-5, 5, -1, -1, 12'h555, 8, 12'h404, -256, 12'h0f0};
        av   = '{-1, 1, 5};
        bv   = '{1, -1, 5};

        begin_prog();
        put(itype(-7, 0, rv_pkg::F3_ADD, 1, rv_pkg::OPC_OP_IMM));
        put(itype(3, 0, rv_pkg::F3_ADD, 2, rv_pkg::OPC_OP_IMM));
        for (int i = 0; i < 20; i++) begin
            put(rtype(alts[i % 10], (i < 10) ? 2 : 1, (i < 10) ? 1 : 2, f3s[i % 10], 3));
            put_sw(3);
        end
        run_prog("alu_reg");

        begin_prog();
        put({20'hf0000, 5'd1, rv_pkg::OPC_LUI});
        put(itype(12'h123, 1, rv_pkg::F3_ADD, 1, rv_pkg::OPC_OP_IMM));
        for (int i = 0; i < 9; i++) begin
            put(itype(imms[i], 1, f3s[i + 1], 3, rv_pkg::OPC_OP_IMM));
            put_sw(3);
        end
        put({20'habcde, 5'd4, rv_pkg::OPC_LUI});
        put_sw(4);
        put({20'h12345, 5'd5, rv_pkg::OPC_AUIPC});
        put_sw(5);
        put({20'hfffff, 5'd6, rv_pkg::OPC_AUIPC});
        put_sw(6);
        run_prog("alu_imm");

        begin_prog();
        for (int c = 0; c < 6; c++) begin
            for (int p = 0; p < 3; p++) begin
                f3 = (c < 2) ? 3'(c) : 3'(c + 2);
                put(itype(av[p], 0, rv_pkg::F3_ADD, 1, rv_pkg::OPC_OP_IMM));
                put(itype(bv[p], 0, rv_pkg::F3_ADD, 2, rv_pkg::OPC_OP_IMM));
                put(itype(c * 8 + p, 0, rv_pkg::F3_ADD, 3, rv_pkg::OPC_OP_IMM));
                put(btype(12, 2, 1, f3));  // Taken skips the first store
                put_sw(3);
                put_sw(3);
            end
        end
        put(itype(0, 0, rv_pkg::F3_ADD, 1, rv_pkg::OPC_OP_IMM));
        put(itype(5, 0, rv_pkg::F3_ADD, 2, rv_pkg::OPC_OP_IMM));
        put(itype(1, 1, rv_pkg::F3_ADD, 1, rv_pkg::OPC_OP_IMM));  // Counting loop
        put_sw(1);
        put(btype(-12, 2, 1, rv_pkg::F3_BNE));
        run_prog("branches");

        begin_prog();
        put(jtype(12, 5));
        put(itype(1, 0, rv_pkg::F3_ADD, 6, rv_pkg::OPC_OP_IMM));
        put(itype(2, 0, rv_pkg::F3_ADD, 6, rv_pkg::OPC_OP_IMM));
        put_sw(5);
        put_sw(6);
        put({20'h0, 5'd7, rv_pkg::OPC_AUIPC});
        put(itype(17, 7, rv_pkg::F3_ADD, 7, rv_pkg::OPC_OP_IMM));  // Odd target
        put(itype(0, 7, 3'b000, 8, rv_pkg::OPC_JALR));
        put(itype(1, 0, rv_pkg::F3_ADD, 9, rv_pkg::OPC_OP_IMM));
        put({20'h0, 5'd10, rv_pkg::OPC_AUIPC});  // JALR target, captures its own PC
        put_sw(8);
        put_sw(9);
        put_sw(10);
        run_prog("jumps");

        begin_prog();
        put(itype(5, 0, rv_pkg::F3_ADD, 0, rv_pkg::OPC_OP_IMM));
        put({20'h12345, 5'd0, rv_pkg::OPC_LUI});
        put(jtype(8, 0));
        put(itype(9, 0, rv_pkg::F3_ADD, 0, rv_pkg::OPC_OP_IMM));
        put(rtype(0, 31, 31, rv_pkg::F3_ADD, 0));
        put_sw(0);
        run_prog("x0_writes");

        begin_prog();
        for (int r = 1; r < 8; r++) begin
            put({20'($random(seed)), 5'(r), rv_pkg::OPC_LUI});
            put(itype($random(seed), r, rv_pkg::F3_ADD, r, rv_pkg::OPC_OP_IMM));
        end
        for (int i = 0; i < 40; i++) begin
            f3  = 3'($random(seed));
            rd  = 1 + $unsigned($random(seed)) % 7;
            alt = $random(seed);
            if ($random(seed) & 1) begin
                put(rtype(alt && (f3 == 0 || f3 == 5), $unsigned($random(seed)) % 8,
                          $unsigned($random(seed)) % 8, f3, rd));
            end else if (f3 == 1 || f3 == 5) begin
                put(itype({1'b0, alt && f3 == 5, 5'b0, 5'($random(seed))},
                          $unsigned($random(seed)) % 8, f3, rd, rv_pkg::OPC_OP_IMM));
            end else begin
                put(itype($random(seed), $unsigned($random(seed)) % 8, f3, rd,
                          rv_pkg::OPC_OP_IMM));
            end
        end
        for (int r = 1; r < 8; r++) put_sw(r);
        run_prog("random_alu");

        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- test/rv_core_props.sv
`timescale 1ns/1ns
`default_nettype none

module rv_core_props (
    input wire                  clk,
    input wire                  rst_n,
    input rv_pkg::wb_req_t      ibus_req,
    input rv_pkg::wb_rsp_t      ibus_rsp,
    input rv_pkg::wb_req_t      dbus_req,
    input rv_pkg::wb_rsp_t      dbus_rsp,
    input rv_pkg::fetch_state_e fetch_state
);

    int fail_count = 0;  // Failed assertions so far

    // --------------------------------------------------
    // Wishbone classic handshake
    // --------------------------------------------------
    ibus_stb_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        ibus_req.stb |-> ibus_req.cyc)
        else begin
            $error("ibus stb without cyc");
            fail_count++;
        end

    dbus_stb_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        dbus_req.stb |-> dbus_req.cyc)
        else begin
            $error("dbus stb without cyc");
            fail_count++;
        end

    ibus_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (ibus_req.stb && !ibus_rsp.ack) |=> $stable(ibus_req))
        else begin
            $error("ibus request changed before ack");
            fail_count++;
        end

    dbus_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (dbus_req.stb && !dbus_rsp.ack) |=> $stable(dbus_req))
        else begin
            $error("dbus request changed before ack");
            fail_count++;
        end

    ibus_read_only: assert property (@(posedge clk) disable iff (!rst_n)
        !ibus_req.we)
        else begin
            $error("ibus write");
            fail_count++;
        end

    dbus_write_only: assert property (@(posedge clk) disable iff (!rst_n)
        dbus_req.stb |-> dbus_req.we)
        else begin
            $error("dbus strobe without we");
            fail_count++;
        end

    one_bus: assert property (@(posedge clk) disable iff (!rst_n)
        !(ibus_req.stb && dbus_req.stb))
        else begin
            $error("both buses strobed");
            fail_count++;
        end

    // Stores only run while the sequencer waits
    store_in_resume: assert property (@(posedge clk) disable iff (!rst_n)
        dbus_req.stb |-> (fetch_state == rv_pkg::RESUME))
        else begin
            $error("data bus active outside RESUME");
            fail_count++;
        end

endmodule

bind rv_core rv_core_props i_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .ibus_req    (ibus_req_o),
    .ibus_rsp    (ibus_rsp_i),
    .dbus_req    (dbus_req_o),
    .dbus_rsp    (dbus_rsp_i),
    .fetch_state (i_fetch.state)
);

`default_nettype wire

//--- src/rv_core.sv
`timescale 1ns/1ns
`default_nettype none

module rv_core (
    input  wire                 clk,
    input  wire                 rst_n,
    output rv_pkg::wb_req_t     ibus_req_o,
    input  rv_pkg::wb_rsp_t     ibus_rsp_i,
    output rv_pkg::wb_req_t     dbus_req_o,
    input  rv_pkg::wb_rsp_t     dbus_rsp_i
);

    rv_pkg::word_t     instr;
    rv_pkg::word_t     pc;
    logic              exec_valid;
    rv_pkg::dec_ctrl_t ctrl;
    rv_pkg::word_t     imm;
    rv_pkg::word_t     rs1_data;
    rv_pkg::word_t     rs2_data;
    rv_pkg::word_t     rd_data;
    rv_pkg::word_t     next_pc;
    rv_pkg::word_t     store_adr;
    rv_pkg::word_t     store_dat;
    logic              store_busy;
    logic              store_start;
    logic              rf_wr;

    // Side effects only in the EXEC cycle
    assign store_start = exec_valid && ctrl.is_store;
    assign rf_wr       = exec_valid && ctrl.rd_wr;

    rv_fetch i_fetch (
        .clk          (clk),
        .rst_n        (rst_n),
        .ibus_req_o   (ibus_req_o),
        .ibus_rsp_i   (ibus_rsp_i),
        .next_pc_i    (next_pc),
        .store_busy_i (store_busy),
        .instr_o      (instr),
        .pc_o         (pc),
        .exec_valid_o (exec_valid)
    );

    rv_decode i_decode (
        .instr_i (instr),
        .ctrl_o  (ctrl),
        .imm_o   (imm)
    );

    rv_regfile i_regfile (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1_i      (ctrl.rs1),
        .rs2_i      (ctrl.rs2),
        .rd_i       (ctrl.rd),
        .wr_i       (rf_wr),
        .wr_data_i  (rd_data),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    rv_execute i_execute (
        .ctrl_i      (ctrl),
        .imm_i       (imm),
        .pc_i        (pc),
        .rs1_data_i  (rs1_data),
        .rs2_data_i  (rs2_data),
        .rd_data_o   (rd_data),
        .next_pc_o   (next_pc),
        .store_adr_o (store_adr),
        .store_dat_o (store_dat)
    );

    rv_store_port i_store_port (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_i    (store_start),
        .adr_i      (store_adr),
        .dat_i      (store_dat),
        .dbus_req_o (dbus_req_o),
        .dbus_rsp_i (dbus_rsp_i),
        .busy_o     (store_busy)
    );

endmodule

`default_nettype wire

//--- src/rv_store_port.sv
`timescale 1ns/1ns
`default_nettype none

module rv_store_port (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 start_i,
    input  rv_pkg::word_t       adr_i,
    input  rv_pkg::word_t       dat_i,
    output rv_pkg::wb_req_t     dbus_req_o,
    input  rv_pkg::wb_rsp_t     dbus_rsp_i,
    output logic                busy_o
);

    logic          busy;
    rv_pkg::word_t adr_q;
    rv_pkg::word_t dat_q;

    // One write in flight, ends the cycle after ack
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (start_i) begin
            busy <= 1'b1;
        end else if (busy && dbus_rsp_i.ack) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            adr_q <= adr_i;
            dat_q <= dat_i;
        end
    end

    // --------------------------------------------------
    // Data bus, full word writes only
    // --------------------------------------------------
    always_comb begin
        dbus_req_o.cyc = busy;
        dbus_req_o.stb = busy;
        dbus_req_o.we  = busy;
        dbus_req_o.adr = adr_q;
        dbus_req_o.dat = dat_q;
    end

    assign busy_o = busy;

endmodule

`default_nettype wire

//--- src/rv_execute.sv
`timescale 1ns/1ns
`default_nettype none

module rv_execute (
    input  rv_pkg::dec_ctrl_t ctrl_i,
    input  rv_pkg::word_t     imm_i,
    input  rv_pkg::word_t     pc_i,
    input  rv_pkg::word_t     rs1_data_i,
    input  rv_pkg::word_t     rs2_data_i,
    output rv_pkg::word_t     rd_data_o,
    output rv_pkg::word_t     next_pc_o,
    output rv_pkg::word_t     store_adr_o,
    output rv_pkg::word_t     store_dat_o
);

    rv_pkg::word_t op_b;
    logic [4:0]    shamt;
    rv_pkg::word_t alu_res;
    rv_pkg::word_t pc_plus4;
    rv_pkg::word_t pc_plus_imm;
    rv_pkg::word_t rs1_plus_imm;
    logic          cmp_eq;
    logic          cmp_lt;
    logic          cmp_ltu;
    logic          cond;
    logic          taken;

    // --------------------------------------------------
    // ALU
    // --------------------------------------------------
    assign op_b  = ctrl_i.use_imm ? imm_i : rs2_data_i;
    assign shamt = op_b[4:0];

    always_comb begin
        case (ctrl_i.funct3)
            rv_pkg::F3_ADD:  alu_res = ctrl_i.alt ? rs1_data_i - op_b : rs1_data_i + op_b;
            rv_pkg::F3_SLL:  alu_res = rs1_data_i << shamt;
            rv_pkg::F3_SLT:  alu_res = {31'b0, $signed(rs1_data_i) < $signed(op_b)};
            rv_pkg::F3_SLTU: alu_res = {31'b0, rs1_data_i < op_b};
            rv_pkg::F3_XOR:  alu_res = rs1_data_i ^ op_b;
            rv_pkg::F3_SR: begin
                if (ctrl_i.alt) begin
                    alu_res = $signed(rs1_data_i) >>> shamt;  // SRA
                end else begin
                    alu_res = rs1_data_i >> shamt;
                end
            end
            rv_pkg::F3_OR:   alu_res = rs1_data_i | op_b;
            default:         alu_res = rs1_data_i & op_b;  // AND
        endcase
    end

    // --------------------------------------------------
    // Branch condition
    // --------------------------------------------------
    assign cmp_eq  = (rs1_data_i == rs2_data_i);
    assign cmp_lt  = ($signed(rs1_data_i) < $signed(rs2_data_i));
    assign cmp_ltu = (rs1_data_i < rs2_data_i);

    always_comb begin
        case (ctrl_i.funct3)
            rv_pkg::F3_BEQ:  cond = cmp_eq;
            rv_pkg::F3_BNE:  cond = !cmp_eq;
            rv_pkg::F3_BLT:  cond = cmp_lt;
            rv_pkg::F3_BGE:  cond = !cmp_lt;
            rv_pkg::F3_BLTU: cond = cmp_ltu;
            rv_pkg::F3_BGEU: cond = !cmp_ltu;
            default:         cond = 1'b0;  // Reserved encodings fall through
        endcase
    end

    assign taken = ctrl_i.is_branch && cond;

    // Adders shared by link, target and store address
    assign pc_plus4     = pc_i + 32'd4;
    assign pc_plus_imm  = pc_i + imm_i;
    assign rs1_plus_imm = rs1_data_i + imm_i;

    always_comb begin
        if (ctrl_i.is_lui) begin
            rd_data_o = imm_i;
        end else if (ctrl_i.is_auipc) begin
            rd_data_o = pc_plus_imm;
        end else if (ctrl_i.is_jal || ctrl_i.is_jalr) begin
            rd_data_o = pc_plus4;  // Link
        end else begin
            rd_data_o = alu_res;
        end
    end

    always_comb begin
        if (ctrl_i.is_jalr) begin
            next_pc_o = {rs1_plus_imm[31:1], 1'b0};
        end else if (ctrl_i.is_jal || taken) begin
            next_pc_o = pc_plus_imm;
        end else begin
            next_pc_o = pc_plus4;
        end
    end

    assign store_adr_o = rs1_plus_imm;
    assign store_dat_o = rs2_data_i;

endmodule

`default_nettype wire

//--- src/rv_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module rv_regfile (
    input  wire                 clk,
    input  wire                 rst_n,
    input  rv_pkg::reg_addr_t   rs1_i,
    input  rv_pkg::reg_addr_t   rs2_i,
    input  rv_pkg::reg_addr_t   rd_i,
    input  wire                 wr_i,
    input  rv_pkg::word_t       wr_data_i,
    output rv_pkg::word_t       rs1_data_o,
    output rv_pkg::word_t       rs2_data_o
);

    rv_pkg::word_t regs [1:31];  // x0 has no storage

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i && rd_i != 5'd0) begin
            regs[rd_i] <= wr_data_i;
        end
    end

    // Asynchronous reads
    assign rs1_data_o = (rs1_i == 5'd0) ? '0 : regs[rs1_i];
    assign rs2_data_o = (rs2_i == 5'd0) ? '0 : regs[rs2_i];

endmodule

`default_nettype wire

//--- src/rv_decode.sv
`timescale 1ns/1ns
`default_nettype none

module rv_decode (
    input  rv_pkg::word_t     instr_i,
    output rv_pkg::dec_ctrl_t ctrl_o,
    output rv_pkg::word_t     imm_o
);

    logic [6:0]    opcode;
    logic [2:0]    funct3;
    rv_pkg::word_t imm_i_type;
    rv_pkg::word_t imm_s_type;
    rv_pkg::word_t imm_b_type;
    rv_pkg::word_t imm_u_type;
    rv_pkg::word_t imm_j_type;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];

    // --------------------------------------------------
    // Immediate formats, all sign extended from bit 31
    // --------------------------------------------------
    assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                         instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_u_type = {instr_i[31:12], 12'b0};
    assign imm_j_type = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                         instr_i[20], instr_i[30:21], 1'b0};

    always_comb begin
        ctrl_o = '0;  // Unknown opcode acts as a no-op
        imm_o  = '0;
        case (opcode)
            rv_pkg::OPC_OP: begin
                ctrl_o.rs1    = instr_i[19:15];
                ctrl_o.rs2    = instr_i[24:20];
                ctrl_o.rd_wr  = 1'b1;
                ctrl_o.funct3 = funct3;
                ctrl_o.alt    = instr_i[30];
            end
            rv_pkg::OPC_OP_IMM: begin
                ctrl_o.rs1     = instr_i[19:15];
                ctrl_o.rd_wr   = 1'b1;
                ctrl_o.use_imm = 1'b1;
                ctrl_o.funct3  = funct3;
                // No SUBI, so alt only matters for shifts right
                ctrl_o.alt     = (funct3 == rv_pkg::F3_SR) && instr_i[30];
                imm_o          = imm_i_type;
            end
            rv_pkg::OPC_LUI: begin
                ctrl_o.rd_wr  = 1'b1;
                ctrl_o.is_lui = 1'b1;
                imm_o         = imm_u_type;
            end
            rv_pkg::OPC_AUIPC: begin
                ctrl_o.rd_wr    = 1'b1;
                ctrl_o.is_auipc = 1'b1;
                imm_o           = imm_u_type;
            end
            rv_pkg::OPC_BRANCH: begin
                ctrl_o.rs1       = instr_i[19:15];
                ctrl_o.rs2       = instr_i[24:20];
                ctrl_o.funct3    = funct3;
                ctrl_o.is_branch = 1'b1;
                imm_o            = imm_b_type;
            end
            rv_pkg::OPC_JAL: begin
                ctrl_o.rd_wr  = 1'b1;
                ctrl_o.is_jal = 1'b1;
                imm_o         = imm_j_type;
            end
            rv_pkg::OPC_JALR: begin
                ctrl_o.rs1     = instr_i[19:15];
                ctrl_o.rd_wr   = 1'b1;
                ctrl_o.is_jalr = 1'b1;
                imm_o          = imm_i_type;
            end
            rv_pkg::OPC_STORE: begin
                ctrl_o.rs1      = instr_i[19:15];
                ctrl_o.rs2      = instr_i[24:20];
                ctrl_o.is_store = 1'b1;  // Always a word
                imm_o           = imm_s_type;
            end
            default: begin
                ctrl_o = '0;
            end
        endcase

        // Writing classes carry rd, x0 target drops the write
        if (ctrl_o.rd_wr) begin
            ctrl_o.rd    = instr_i[11:7];
            ctrl_o.rd_wr = (instr_i[11:7] != 5'd0);
        end
    end

endmodule

`default_nettype wire

//--- src/rv_fetch.sv
`timescale 1ns/1ns
`default_nettype none

module rv_fetch (
    input  wire                 clk,
    input  wire                 rst_n,
    output rv_pkg::wb_req_t     ibus_req_o,
    input  rv_pkg::wb_rsp_t     ibus_rsp_i,
    input  rv_pkg::word_t       next_pc_i,
    input  wire                 store_busy_i,
    output rv_pkg::word_t       instr_o,
    output rv_pkg::word_t       pc_o,
    output logic                exec_valid_o
);

    rv_pkg::fetch_state_e state;
    rv_pkg::word_t        pc;
    rv_pkg::word_t        instr;

    // --------------------------------------------------
    // Sequencer
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= rv_pkg::FETCH;
        end else begin
            case (state)
                rv_pkg::FETCH: begin
                    if (ibus_rsp_i.ack) begin
                        state <= rv_pkg::EXEC;
                    end
                end
                rv_pkg::EXEC: begin
                    state <= rv_pkg::RESUME;  // Always one cycle here
                end
                rv_pkg::RESUME: begin
                    if (!store_busy_i) begin
                        state <= rv_pkg::FETCH;
                    end
                end
                default: begin
                    state <= rv_pkg::FETCH;
                end
            endcase
        end
    end

    // PC moves on at the end of EXEC
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= rv_pkg::RESET_PC;
        end else if (state == rv_pkg::EXEC) begin
            pc <= next_pc_i;
        end
    end

    // Instruction word captured with the ack
    always_ff @(posedge clk) begin
        if (state == rv_pkg::FETCH && ibus_rsp_i.ack) begin
            instr <= ibus_rsp_i.dat;
        end
    end

    // --------------------------------------------------
    // Instruction bus, read only
    // --------------------------------------------------
    always_comb begin
        ibus_req_o.cyc = (state == rv_pkg::FETCH);
        ibus_req_o.stb = (state == rv_pkg::FETCH);
        ibus_req_o.we  = 1'b0;
        ibus_req_o.adr = pc;
        ibus_req_o.dat = '0;
    end

    assign instr_o      = instr;
    assign pc_o         = pc;
    assign exec_valid_o = (state == rv_pkg::EXEC);

endmodule

`default_nettype wire

//--- src/rv_pkg.sv
`default_nettype none

package rv_pkg;

    // --------------------------------------------------
    // Widths and basic types
    // --------------------------------------------------
    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;      // Data, address, instruction
    typedef logic [4:0]      reg_addr_t;  // Register index

    localparam word_t RESET_PC = 32'h0000_0000;

    // --------------------------------------------------
    // Major opcodes
    // --------------------------------------------------
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    // ALU funct3
    localparam logic [2:0] F3_ADD  = 3'b000;  // Also SUB with alt
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;  // SRL, SRA with alt
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // Branch funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // --------------------------------------------------
    // Wishbone classic bundles
    // --------------------------------------------------
    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        word_t adr;
        word_t dat;
    } wb_req_t;

    typedef struct packed {
        word_t dat;
        logic  ack;
    } wb_rsp_t;

    // Decoded instruction
    typedef struct packed {
        reg_addr_t  rd;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        logic [2:0] funct3;
        logic       alt;        // funct7[5]
        logic       rd_wr;
        logic       use_imm;
        logic       is_branch;
        logic       is_jal;
        logic       is_jalr;
        logic       is_lui;
        logic       is_auipc;
        logic       is_store;
    } dec_ctrl_t;

    typedef enum logic [1:0] {
        FETCH,
        EXEC,
        RESUME
    } fetch_state_e;

endpackage

`default_nettype wire
